// ==== dv/cdc_fifo_tb.sv ====
// Testbench for the dual-clock tagged FIFO.
// Streams numbered entries across two drifting clocks and checks order and data.
`default_nettype none

module cdc_fifo_tb import cdc_fifo_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DEPTH        = 16;
  localparam int SYNC_STAGES  = 2;
  localparam int STREAM_COUNT = 300;
  localparam int FULL_HOLD    = 40;
  localparam int DATA_MULT    = 40503;
  // Seed folded to the 16-bit register width.
  localparam logic [15:0] LFSR_SEED = 16'(90676);

  localparam int RESET_WAIT_MAX  = 100;
  localparam int WRITE_STALL_MAX = 2000;
  localparam int READ_CYCLES_MAX = 20000;
  localparam int FILL_CYCLES_MAX = 500;
  localparam int DRAIN_MAX       = 200;
  localparam int READY_WAIT_MAX  = 100;

  logic        wclk;
  logic        wrstn;
  logic        rclk;
  logic        rrstn;
  fifo_entry_t w_entry;
  logic        w_valid;
  logic        w_ready;
  fifo_entry_t r_entry;
  logic        r_valid;
  logic        r_ready;

  int          err_count    = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;
  int          tx_count     = 0;
  int          rx_count     = 0;
  int          hold_checks  = 0;
  int          hold_errs    = 0;
  bit          timed_out    = 1'b0;
  bit          check_en     = 1'b0;
  logic [15:0] wr_lfsr      = LFSR_SEED;
  logic [15:0] rd_lfsr      = LFSR_SEED;

  tb_clk_gen #(.PERIOD_NS(10), .RESET_CYCLES(8)) u_rclk_gen (.clk(rclk), .rstn(rrstn));
  tb_clk_gen #(.PERIOD_NS(14), .RESET_CYCLES(8)) u_wclk_gen (.clk(wclk), .rstn(wrstn));

  cdc_fifo_top #(
    .DEPTH       (DEPTH),
    .SYNC_STAGES (SYNC_STAGES)
  ) dut (
    .wclk    (wclk),
    .wrstn   (wrstn),
    .w_entry (w_entry),
    .w_valid (w_valid),
    .w_ready (w_ready),
    .rclk    (rclk),
    .rrstn   (rrstn),
    .r_entry (r_entry),
    .r_valid (r_valid),
    .r_ready (r_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and random bits
  ////////////////////////////////////////////////////////////////////////////

  // Entry number n carries the low bits of n as tag and a scrambled data word.
  function automatic fifo_entry_t expected_entry(input int n);
    fifo_entry_t e;
    e.tag  = n[TAG_W-1:0];
    e.data = DATA_W'(n * DATA_MULT);
    return e;
  endfunction

  // Fibonacci LFSR, taps 16 14 13 11.
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
  endfunction

  function automatic logic take_wbit();
    wr_lfsr = lfsr_step(wr_lfsr);
    return wr_lfsr[0];
  endfunction

  function automatic logic take_rbit();
    rd_lfsr = lfsr_step(rd_lfsr);
    return rd_lfsr[0];
  endfunction

  task automatic report_test(input string name, input int errs);
    tests_run++;
    if (errs == 0) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: failed with %0d errors", name, errs);
      tests_failed++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("Timeout: %s", what);
    err_count++;
    timed_out = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Read-side checker
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge rclk) begin : rx_check
    fifo_entry_t exp_entry;
    fifo_entry_t held_entry;
    bit          hold_pending;
    if (check_en) begin
      // A stalled word must not change.
      if (hold_pending) begin
        hold_checks++;
        assert (r_valid && r_entry == held_entry) else begin
          $display("Fail: r_entry hold expected %h got %h (r_valid %h)",
                   held_entry, r_entry, r_valid);
          err_count++;
          hold_errs++;
        end
      end
      if (r_valid && r_ready) begin
        assert (rx_count < tx_count) else begin
          $display("Entry read out that was never written");
          err_count++;
        end
        exp_entry = expected_entry(rx_count);
        assert (r_entry == exp_entry) else begin
          $display("Fail: r_entry expected %h got %h", exp_entry, r_entry);
          err_count++;
        end
        rx_count++;
      end
      hold_pending = r_valid && !r_ready;
      held_entry   = r_entry;
    end else begin
      hold_pending = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic write_entries(input int count);
    int sent;
    int stall;
    bit accepted;
    sent  = 0;
    stall = 0;
    while (sent < count && stall < WRITE_STALL_MAX) begin
      @(posedge wclk);
      accepted = w_valid && w_ready;
      if (accepted) begin
        sent++;
        tx_count++;
        stall = 0;
      end else if (w_valid) begin
        stall++;
      end
      #1;
      if (accepted || !w_valid) begin
        if (sent < count && take_wbit()) begin
          w_entry = expected_entry(tx_count);
          w_valid = 1'b1;
        end else begin
          w_valid = 1'b0;
        end
      end
    end
    w_valid = 1'b0;
    if (stall >= WRITE_STALL_MAX) begin
      note_timeout("writer stalled with w_ready low");
    end
  endtask

  // Slow reader for the first half so the FIFO fills, fast for the rest.
  task automatic read_entries(input int count);
    int   target;
    int   cycles;
    logic b0;
    logic b1;
    target = rx_count + count;
    cycles = 0;
    while (rx_count < target && cycles < READ_CYCLES_MAX) begin
      @(posedge rclk);
      #1;
      cycles++;
      b0 = take_rbit();
      b1 = take_rbit();
      if (rx_count >= target) begin
        r_ready = 1'b0;
      end else if (target - rx_count > count / 2) begin
        r_ready = b0 && b1;
      end else begin
        r_ready = b0 || b1;
      end
    end
    r_ready = 1'b0;
    if (rx_count < target) begin
      note_timeout("reader did not receive all streamed entries");
    end
  endtask

  task automatic fill_until_full(output int accepted);
    int low_run;
    int cycles;
    accepted = 0;
    low_run  = 0;
    cycles   = 0;
    while (low_run < FULL_HOLD && cycles < FILL_CYCLES_MAX) begin
      @(posedge wclk);
      cycles++;
      if (w_valid && w_ready) begin
        accepted++;
        tx_count++;
        low_run = 0;
      end else if (w_valid && !w_ready) begin
        low_run++;
      end
      #1;
      w_entry = expected_entry(tx_count);
      w_valid = 1'b1;
    end
    w_valid = 1'b0;
    if (low_run < FULL_HOLD) begin
      note_timeout("w_ready never stayed low while filling");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    int  mark;
    int  cycles;
    int  accepted;
    int  start;
    bit  done;
    w_entry = '0;
    w_valid = 1'b0;
    r_ready = 1'b0;

    // Test 1: state after reset.
    mark   = err_count;
    cycles = 0;
    while (!(wrstn && rrstn) && cycles < RESET_WAIT_MAX) begin
      @(posedge rclk);
      cycles++;
    end
    if (!(wrstn && rrstn)) begin
      note_timeout("resets were not released");
    end
    @(posedge rclk);
    assert (r_valid == 1'b0) else begin
      $display("Fail: r_valid expected %h got %h", 1'b0, r_valid);
      err_count++;
    end
    @(posedge wclk);
    assert (w_ready == 1'b1) else begin
      $display("Fail: w_ready expected %h got %h", 1'b1, w_ready);
      err_count++;
    end
    report_test("1 reset state", err_count - mark);
    check_en = 1'b1;

    // Test 2: random streaming.
    if (!timed_out) begin
      mark = err_count;
      fork
        write_entries(STREAM_COUNT);
        read_entries(STREAM_COUNT);
      join
      report_test("2 streaming", err_count - mark);
    end

    // Test 3: fill with the reader stalled.
    if (!timed_out) begin
      mark = err_count;
      fill_until_full(accepted);
      assert (accepted == DEPTH + 2) else begin
        $display("Fail: w_ready accept count expected %h got %h", DEPTH + 2, accepted);
        err_count++;
      end
      assert (r_valid) else begin
        $display("r_valid did not rise while the FIFO was full");
        err_count++;
      end
      report_test("3 full", err_count - mark);
      if (hold_checks == 0) begin
        $display("No back-pressure cycle was seen");
        err_count++;
      end
      report_test("4 back-pressure hold", hold_errs + (hold_checks == 0 ? 1 : 0));
    end

    // Test 5: drain after full.
    if (!timed_out) begin
      mark  = err_count;
      start = rx_count;
      @(posedge rclk);
      #1;
      r_ready = 1'b1;
      cycles  = 0;
      done    = 1'b0;
      while (!done && cycles < DRAIN_MAX) begin
        @(posedge rclk);
        cycles++;
        done = (rx_count >= tx_count) && !r_valid;
      end
      if (!done) begin
        note_timeout("r_valid did not fall after draining");
      end
      assert (rx_count - start == DEPTH + 2) else begin
        $display("Fail: drained count expected %h got %h", DEPTH + 2, rx_count - start);
        err_count++;
      end
      cycles = 0;
      done   = 1'b0;
      while (!done && cycles < READY_WAIT_MAX) begin
        @(posedge wclk);
        cycles++;
        done = w_ready;
      end
      if (!done) begin
        note_timeout("w_ready did not return high after draining");
      end
      r_ready = 1'b0;
      report_test("5 drain after full", err_count - mark);
    end

    $display("Summary: %0d tests run, %0d failed, %0d errors, %0d entries checked",
             tests_run, tests_failed, err_count, rx_count);
    if (err_count == 0 && !timed_out) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
// Clock and reset source for the FIFO testbench.
// Reset stays low for a fixed number of clock cycles.
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rstn
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk = ~clk;
    end
  end

  // Release on a falling edge, away from the active edge.
  initial begin
    rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
  end

endmodule

`default_nettype wire

// ==== project.f ====
rtl/cdc_fifo_pkg.sv
rtl/gray_sync.sv
rtl/fifo_ptr_ctrl.sv
rtl/fifo_mem.sv
rtl/fifo_out_stage.sv
rtl/cdc_fifo_top.sv
dv/tb_clk_gen.sv
dv/cdc_fifo_tb.sv

// ==== rtl/cdc_fifo_pkg.sv ====
// Shared definitions for the dual-clock tagged FIFO.
// Holds the entry layout and the Gray code helpers for pointer crossing.
`default_nettype none

package cdc_fifo_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Entry layout
  ////////////////////////////////////////////////////////////////////////////

  // Width of the data word.
  localparam int DATA_W = 16;

  // Width of the tag.
  localparam int TAG_W = 4;

  // One FIFO entry, tag in the upper bits.
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] data;
  } fifo_entry_t;

  ////////////////////////////////////////////////////////////////////////////
  // Gray code helpers
  ////////////////////////////////////////////////////////////////////////////

  // Widest pointer the helpers handle; narrower values are zero extended.
  localparam int GRAY_MAX_W = 16;

  // Binary to reflected Gray code.
  function automatic logic [GRAY_MAX_W-1:0] bin2gray(
    input logic [GRAY_MAX_W-1:0] bin
  );
    return bin ^ (bin >> 1);
  endfunction

  // Reflected Gray code back to binary.
  // Leading zeros from extension stay zero, so short pointers convert correctly.
  function automatic logic [GRAY_MAX_W-1:0] gray2bin(
    input logic [GRAY_MAX_W-1:0] gray
  );
    logic [GRAY_MAX_W-1:0] bin;
    bin[GRAY_MAX_W-1] = gray[GRAY_MAX_W-1];
    for (int i = GRAY_MAX_W - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/cdc_fifo_top.sv ====
// Dual-clock tagged FIFO, top level.
// Wires pointer control, storage and the read-side output stage.
`default_nettype none

module cdc_fifo_top import cdc_fifo_pkg::*; #(
  parameter int DEPTH       = 16,
  parameter int SYNC_STAGES = 2
) (
  input  wire logic        wclk,
  input  wire logic        wrstn,
  input  wire fifo_entry_t w_entry,
  input  wire logic        w_valid,
  output logic             w_ready,
  input  wire logic        rclk,
  input  wire logic        rrstn,
  output fifo_entry_t      r_entry,
  output logic             r_valid,
  input  wire logic        r_ready
);

  localparam int AW = $clog2(DEPTH);

  logic          mem_we;
  logic [AW-1:0] mem_waddr;
  logic          mem_re;
  logic [AW-1:0] mem_raddr;
  logic          fill_valid;
  logic          out_room;
  fifo_entry_t   rd_entry;

  fifo_ptr_ctrl #(
    .DEPTH       (DEPTH),
    .SYNC_STAGES (SYNC_STAGES)
  ) u_ptr_ctrl (
    .wclk       (wclk),
    .wrstn      (wrstn),
    .rclk       (rclk),
    .rrstn      (rrstn),
    .w_valid    (w_valid),
    .out_room   (out_room),
    .w_ready    (w_ready),
    .mem_we     (mem_we),
    .mem_waddr  (mem_waddr),
    .mem_re     (mem_re),
    .mem_raddr  (mem_raddr),
    .fill_valid (fill_valid)
  );

  // Write data goes straight to the array.
  fifo_mem #(
    .DEPTH (DEPTH)
  ) u_mem (
    .wclk      (wclk),
    .rclk      (rclk),
    .mem_we    (mem_we),
    .mem_waddr (mem_waddr),
    .w_entry   (w_entry),
    .mem_re    (mem_re),
    .mem_raddr (mem_raddr),
    .rd_entry  (rd_entry)
  );

  fifo_out_stage u_out_stage (
    .rclk       (rclk),
    .rrstn      (rrstn),
    .fill_valid (fill_valid),
    .rd_entry   (rd_entry),
    .r_ready    (r_ready),
    .out_room   (out_room),
    .r_valid    (r_valid),
    .r_entry    (r_entry)
  );

endmodule

`default_nettype wire

// ==== rtl/fifo_mem.sv ====
// Dual-clock FIFO storage.
// Write port on wclk, registered read port on rclk.
`default_nettype none

module fifo_mem import cdc_fifo_pkg::*; #(
  parameter int DEPTH = 16
) (
  input  wire logic                     wclk,
  input  wire logic                     rclk,
  input  wire logic                     mem_we,
  input  wire logic [$clog2(DEPTH)-1:0] mem_waddr,
  input  wire fifo_entry_t              w_entry,
  input  wire logic                     mem_re,
  input  wire logic [$clog2(DEPTH)-1:0] mem_raddr,
  output fifo_entry_t                   rd_entry
);

  fifo_entry_t mem_q [DEPTH];

  always_ff @(posedge wclk) begin
    if (mem_we) begin
      mem_q[mem_waddr] <= w_entry;
    end
  end

  // Output holds its value between reads.
  always_ff @(posedge rclk) begin
    if (mem_re) begin
      rd_entry <= mem_q[mem_raddr];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fifo_out_stage.sv ====
// Two-slot output buffer on the read side.
// Covers the memory read latency and holds r_entry under back-pressure.
`default_nettype none

module fifo_out_stage import cdc_fifo_pkg::*; (
  input  wire logic        rclk,
  input  wire logic        rrstn,
  input  wire logic        fill_valid,
  input  wire fifo_entry_t rd_entry,
  input  wire logic        r_ready,
  output logic             out_room,
  output logic             r_valid,
  output fifo_entry_t      r_entry
);

  fifo_entry_t head_q;
  fifo_entry_t spare_q;
  logic        head_vld;
  logic        spare_vld;
  logic        pop;
  logic [1:0]  occ;
  logic [1:0]  occ_after;

  assign pop = head_vld && r_ready;
  assign occ = {1'b0, head_vld} + {1'b0, spare_vld};

  // Occupancy after this edge, including the word now arriving.
  // A read issued now lands next cycle, so one free slot must remain.
  assign occ_after = occ + {1'b0, fill_valid} - {1'b0, pop};
  assign out_room  = !occ_after[1];

  assign r_valid = head_vld;
  assign r_entry = head_q;

  ////////////////////////////////////////////////////////////////////////////
  // Slot state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge rclk or negedge rrstn) begin
    if (!rrstn) begin
      head_vld  <= 1'b0;
      spare_vld <= 1'b0;
    end else if (pop) begin
      // Head stays full if the spare or a new word refills it.
      head_vld  <= spare_vld || fill_valid;
      spare_vld <= spare_vld && fill_valid;
    end else if (fill_valid) begin
      head_vld  <= 1'b1;
      spare_vld <= head_vld;
    end
  end

  always_ff @(posedge rclk) begin
    if (pop) begin
      if (spare_vld) begin
        head_q  <= spare_q;
        spare_q <= rd_entry;
      end else begin
        head_q <= rd_entry;
      end
    end else if (fill_valid) begin
      if (head_vld) begin
        spare_q <= rd_entry;
      end else begin
        head_q <= rd_entry;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fifo_ptr_ctrl.sv ====
// Pointer control for the dual-clock FIFO.
// Crosses Gray pointers both ways, detects full and empty, drives the memory.
`default_nettype none

module fifo_ptr_ctrl import cdc_fifo_pkg::*; #(
  parameter int DEPTH       = 16,
  parameter int SYNC_STAGES = 2
) (
  input  wire logic                     wclk,
  input  wire logic                     wrstn,
  input  wire logic                     rclk,
  input  wire logic                     rrstn,
  input  wire logic                     w_valid,
  input  wire logic                     out_room,
  output logic                          w_ready,
  output logic                          mem_we,
  output logic [$clog2(DEPTH)-1:0]      mem_waddr,
  output logic                          mem_re,
  output logic [$clog2(DEPTH)-1:0]      mem_raddr,
  output logic                          fill_valid
);

  localparam int AW = $clog2(DEPTH);
  // One wrap bit above the address tells full from empty.
  localparam int PW = AW + 1;

  ////////////////////////////////////////////////////////////////////////////
  // Write domain
  ////////////////////////////////////////////////////////////////////////////

  logic [PW-1:0]         wptr_bin;
  logic [PW-1:0]         wptr_next;
  logic [PW-1:0]         wptr_gray_q;
  logic [GRAY_MAX_W-1:0] wnext_gray_ext;
  logic [PW-1:0]         rptr_gray_q;
  logic [PW-1:0]         rptr_gray_wsync;
  logic [GRAY_MAX_W-1:0] rptr_wbin_ext;
  logic [PW-1:0]         rptr_wbin;
  logic                  full;

  // Full when the reader is exactly one lap behind.
  assign full    = (rptr_wbin == {~wptr_bin[PW-1], wptr_bin[AW-1:0]});
  assign w_ready = !full;
  assign mem_we  = w_valid && w_ready;

  assign mem_waddr = wptr_bin[AW-1:0];
  assign wptr_next = mem_we ? wptr_bin + 1'b1 : wptr_bin;

  assign wnext_gray_ext = bin2gray(GRAY_MAX_W'(wptr_next));

  always_ff @(posedge wclk or negedge wrstn) begin
    if (!wrstn) begin
      wptr_bin    <= '0;
      wptr_gray_q <= '0;
    end else begin
      wptr_bin    <= wptr_next;
      wptr_gray_q <= wnext_gray_ext[PW-1:0];
    end
  end

  // Read pointer into the write domain.
  gray_sync #(
    .SYNC_STAGES (SYNC_STAGES),
    .WIDTH       (PW)
  ) u_sync_r2w (
    .clk     (wclk),
    .rstn    (wrstn),
    .d_async (rptr_gray_q),
    .d_sync  (rptr_gray_wsync)
  );

  assign rptr_wbin_ext = gray2bin(GRAY_MAX_W'(rptr_gray_wsync));
  assign rptr_wbin     = rptr_wbin_ext[PW-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Read domain
  ////////////////////////////////////////////////////////////////////////////

  logic [PW-1:0]         rptr_bin;
  logic [PW-1:0]         rptr_next;
  logic [GRAY_MAX_W-1:0] rnext_gray_ext;
  logic [PW-1:0]         wptr_gray_rsync;
  logic [GRAY_MAX_W-1:0] wptr_rbin_ext;
  logic [PW-1:0]         wptr_rbin;
  logic                  empty;

  // Write pointer into the read domain.
  gray_sync #(
    .SYNC_STAGES (SYNC_STAGES),
    .WIDTH       (PW)
  ) u_sync_w2r (
    .clk     (rclk),
    .rstn    (rrstn),
    .d_async (wptr_gray_q),
    .d_sync  (wptr_gray_rsync)
  );

  assign wptr_rbin_ext = gray2bin(GRAY_MAX_W'(wptr_gray_rsync));
  assign wptr_rbin     = wptr_rbin_ext[PW-1:0];

  assign empty     = (wptr_rbin == rptr_bin);
  // Read only when the output stage can take the word.
  assign mem_re    = !empty && out_room;
  assign mem_raddr = rptr_bin[AW-1:0];
  assign rptr_next = mem_re ? rptr_bin + 1'b1 : rptr_bin;

  assign rnext_gray_ext = bin2gray(GRAY_MAX_W'(rptr_next));

  always_ff @(posedge rclk or negedge rrstn) begin
    if (!rrstn) begin
      rptr_bin    <= '0;
      rptr_gray_q <= '0;
      fill_valid  <= 1'b0;
    end else begin
      rptr_bin    <= rptr_next;
      rptr_gray_q <= rnext_gray_ext[PW-1:0];
      // Memory data shows up one cycle after the read.
      fill_valid  <= mem_re;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/gray_sync.sv ====
// Multi-stage flip-flop synchronizer for a Gray-coded pointer.
// Only one bit changes per step, so each rank may sample it safely.
`default_nettype none

module gray_sync #(
  parameter int SYNC_STAGES = 2,
  parameter int WIDTH       = 5
) (
  input  wire logic             clk,
  input  wire logic             rstn,
  input  wire logic [WIDTH-1:0] d_async,
  output logic      [WIDTH-1:0] d_sync
);

  // Rank 0 samples the foreign domain.
  logic [WIDTH-1:0] sync_q [SYNC_STAGES];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= d_async;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign d_sync = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire
